// File: vlog.f
dmm_regs_pkg.sv
dmm_drive_pkg.sv
spi_reg_bank.sv
spi_port_mux.sv
pattern_gen.sv
charge_cycle_seq.sv
drive_select.sv
dmm_fpga_top.sv
tb_dmm_fpga.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the dmm output control testbench with verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 --top-module tb_dmm_fpga -f vlog.f

sim_out="$(./obj_dir/Vtb_dmm_fpga 2>&1)" || true
echo "$sim_out"

if grep -q "TESTBENCH PASSED" <<< "$sim_out"; then
  exit 0
fi
exit 1

// File: tb_dmm_fpga.sv
// dmm output control testbench
// table driven spi master with a register file model, checks the
// readback, the four drive modes and the 4094 port switch
`timescale 1ns/1ps

module tb_dmm_fpga;
  import dmm_regs_pkg::*;

  localparam int PHASE_CYCLES = 16;
  localparam int LOG2_BLINK   = 3;
  // clk per sclk half period
  localparam int HALF_SCLK    = 4;
  localparam int N_ENTRIES    = 26;
  localparam int TIMEOUT_CYCLES = N_ENTRIES * 300 + 2000;

  // switch codes as the charge sequence should drive them
  localparam logic [3:0] GND_SEL     = 4'b1011;
  localparam logic [3:0] DCV_SEL     = 4'b1000;
  localparam logic [3:0] HIMUX_ROUTE = 4'b1001;

  typedef enum logic [2:0] {
    OP_WRITE,
    OP_WRITE_PINS,
    OP_SHORT,
    OP_PATTERN,
    OP_COUNT,
    OP_CHARGE,
    OP_PORT
  } op_t;

  // expect_val is the run length or step count for the named checks
  typedef struct packed {
    op_t         op;
    logic [7:0]  addr;
    logic [23:0] data;
    logic [23:0] expect_val;
  } entry_t;

  logic       clk;
  logic       reset;
  logic       spi_clk;
  logic       spi_cs;
  logic       spi_cs2;
  logic       spi_mosi;
  logic       u1004_4094_data;
  logic       spi_miso;
  logic       glb_4094_clk;
  logic       glb_4094_data;
  logic       glb_4094_strobe;
  logic [3:0] azmux;
  logic [3:0] himux;
  logic [3:0] himux2;
  logic       sig_pc_sw_ctl;
  logic       led0;
  logic [7:0] monitor;

  logic [23:0] reg_model [0:255];
  integer      seed;
  integer      rnd;
  int          cycle_cnt = 0;

  entry_t stim [N_ENTRIES] = '{
    '{OP_PATTERN,    8'h00,       24'h000000,                  24'd8},
    '{OP_WRITE,      REG_LED,     24'h123456,                  24'd0},
    '{OP_WRITE,      REG_SPI_MUX, 24'hA5A5A4,                  24'd0},
    '{OP_WRITE,      REG_DIRECT,  24'h3C0F0F,                  24'd0},
    // upper bits of the mode register are kept for readback
    '{OP_WRITE,      REG_MODE,    {22'h2AF340, MODE_PATTERN},  24'd0},
    '{OP_WRITE,      8'h55,       24'hFFFFFF,                  24'd0},
    '{OP_WRITE,      REG_LED,     24'h654321,                  24'd0},
    '{OP_WRITE,      REG_SPI_MUX, 24'h000000,                  24'd0},
    '{OP_WRITE,      REG_DIRECT,  24'h000000,                  24'd0},
    '{OP_WRITE,      REG_MODE,    {22'h0, MODE_DIRECT},        24'd0},
    '{OP_WRITE,      8'h55,       24'h000000,                  24'd0},
    '{OP_SHORT,      REG_LED,     24'hFFFFFF,                  24'd0},
    '{OP_WRITE,      REG_LED,     24'h000000,                  24'd0},
    '{OP_WRITE_PINS, REG_DIRECT,  24'h000000,                  24'd0},
    '{OP_WRITE_PINS, REG_DIRECT,  24'h000000,                  24'd0},
    '{OP_WRITE_PINS, REG_DIRECT,  24'h000000,                  24'd0},
    '{OP_WRITE,      REG_MODE,    {22'h0, MODE_COUNT},         24'd0},
    '{OP_COUNT,      8'h00,       24'h000000,                  24'd50},
    '{OP_WRITE,      REG_MODE,    {22'h0, MODE_CHARGE},        24'd0},
    '{OP_CHARGE,     8'h00,       24'h000000,                  24'd16},
    '{OP_WRITE,      REG_MODE,    {22'h0, MODE_PATTERN},       24'd0},
    '{OP_PATTERN,    8'h00,       24'h000000,                  24'd8},
    '{OP_WRITE,      REG_SPI_MUX, 24'h000001,                  24'd0},
    '{OP_PORT,       8'h00,       24'h000000,                  24'd1},
    '{OP_WRITE,      REG_SPI_MUX, 24'h000000,                  24'd0},
    '{OP_PORT,       8'h00,       24'h000000,                  24'd0}
  };

  dmm_fpga_top #(
    .PHASE_CYCLES (PHASE_CYCLES),
    .LOG2_BLINK   (LOG2_BLINK)
  ) i_dmm_fpga_top (
    .clk             (clk),
    .reset           (reset),
    .spi_clk         (spi_clk),
    .spi_cs          (spi_cs),
    .spi_cs2         (spi_cs2),
    .spi_mosi        (spi_mosi),
    .u1004_4094_data (u1004_4094_data),
    .spi_miso        (spi_miso),
    .glb_4094_clk    (glb_4094_clk),
    .glb_4094_data   (glb_4094_data),
    .glb_4094_strobe (glb_4094_strobe),
    .azmux           (azmux),
    .himux           (himux),
    .himux2          (himux2),
    .sig_pc_sw_ctl   (sig_pc_sw_ctl),
    .led0            (led0),
    .monitor         (monitor)
  );

  always #5 clk = ~clk;

  //////////////////////////////
  // failure handling

  task automatic stop_failed();
    $display("TESTBENCH FAILED");
    $fatal(1, "stopping on first error");
  endtask

  task automatic expect_equal(input string name, input logic [31:0] exp_val,
                              input logic [31:0] act_val);
    assert (act_val === exp_val)
    else
    begin
      $display("FAIL at %0t: %s expected 0x%0h, got 0x%0h", $time, name, exp_val, act_val);
      stop_failed();
    end
  endtask

  // run limit scaled to the table length
  always @(posedge clk)
  begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= TIMEOUT_CYCLES)
    begin
      $display("timeout after %0d cycles, the test did not finish", cycle_cnt);
      stop_failed();
    end
  end

  //////////////////////////////
  // register file model

  function automatic bit addr_mapped(input logic [7:0] a);
    return (a == REG_LED) || (a == REG_SPI_MUX) || (a == REG_MODE) || (a == REG_DIRECT);
  endfunction

  // old content returned in the data phase or zero when unmapped
  function automatic logic [23:0] expected_read(input logic [7:0] a);
    if (addr_mapped(a))
      return reg_model[a];
    else
      return 24'h0;
  endfunction

  // drive word as seen on the pins with the monitor on top
  function automatic logic [21:0] pins_concat();
    return {monitor, led0, sig_pc_sw_ctl, himux2, himux, azmux};
  endfunction

  //////////////////////////////
  // spi master

  // inputs change 1 ns after the rising edge
  task automatic step_clocks(input int n);
    repeat (n)
    begin
      @(posedge clk);
      #1;
    end
  endtask

  task automatic spi_transfer(input int nbits, input logic [7:0] addr,
                              input logic [23:0] data, output logic [23:0] rd_data);
    logic [31:0] frame;
    logic [31:0] rx;
    int          i;
    frame = {addr, data};
    rx = '0;
    spi_cs = 1'b0;
    for (i = 0; i < nbits; i++)
    begin
      spi_mosi = frame[31];
      frame = frame << 1;
      spi_clk = 1'b0;
      step_clocks(HALF_SCLK);
      // mode 0 sampling just before the rising edge
      rx = {rx[30:0], spi_miso};
      spi_clk = 1'b1;
      step_clocks(HALF_SCLK);
    end
    spi_clk = 1'b0;
    spi_mosi = 1'b0;
    step_clocks(HALF_SCLK);
    spi_cs = 1'b1;
    // register lands 3 clk after cs rises and the pins one clk later
    step_clocks(4);
    rd_data = rx[23:0];
  endtask

  //////////////////////////////
  // mode checks

  task automatic compare_direct_pins(input logic [23:0] d);
    step_clocks(4);
    expect_equal("azmux", 32'(d[3:0]), 32'(azmux));
    expect_equal("himux", 32'(d[7:4]), 32'(himux));
    expect_equal("himux2", 32'(d[11:8]), 32'(himux2));
    expect_equal("sig_pc_sw_ctl", 32'(d[12]), 32'(sig_pc_sw_ctl));
    expect_equal("led0", 32'(d[13]), 32'(led0));
    expect_equal("monitor", 32'(d[21:14]), 32'(monitor));
  endtask

  task automatic watch_pattern(input int blink_run);
    logic [7:0] prev_mon;
    logic [7:0] exp_mon;
    logic       prev_led;
    int         run;
    int         toggles;
    int         k;
    step_clocks(1);
    prev_mon = monitor;
    prev_led = led0;
    run = 1;
    toggles = 0;
    for (k = 0; k < 40; k++)
    begin
      step_clocks(1);
      exp_mon = prev_mon + 8'd1;
      expect_equal("monitor", 32'(exp_mon), 32'(monitor));
      expect_equal("azmux", 32'd0, 32'(azmux));
      expect_equal("himux", 32'd0, 32'(himux));
      expect_equal("himux2", 32'd0, 32'(himux2));
      expect_equal("sig_pc_sw_ctl", 32'd0, 32'(sig_pc_sw_ctl));
      if (led0 == prev_led)
        run++;
      else
      begin
        // first run is partial
        if (toggles > 0)
          expect_equal("led0 run length", 32'(blink_run), 32'(run));
        toggles++;
        run = 1;
      end
      prev_mon = monitor;
      prev_led = led0;
    end
    assert (toggles >= 3)
    else
    begin
      $display("led0 did not blink in pattern mode");
      stop_failed();
    end
  endtask

  task automatic watch_count(input int steps);
    logic [21:0] prev_word;
    logic [21:0] exp_word;
    int          k;
    prev_word = pins_concat();
    for (k = 0; k < steps; k++)
    begin
      step_clocks(1);
      exp_word = prev_word + 22'd1;
      expect_equal("count pin word", 32'(exp_word), 32'(pins_concat()));
      prev_word = pins_concat();
    end
  endtask

  task automatic watch_charge(input int run_len);
    logic [3:0] phase_sel;
    logic       exp_led;
    int         run;
    int         k;
    // restarted ground phase reaches the pins one clock after the transfer returns
    step_clocks(1);
    // ground from the mode write on, then alternating full phases
    for (k = 0; k < 4; k++)
    begin
      phase_sel = (k % 2 == 0) ? GND_SEL : DCV_SEL;
      exp_led = (k % 2 == 1);
      expect_equal("himux2", 32'(phase_sel), 32'(himux2));
      run = 0;
      while (himux2 == phase_sel && run < 40)
      begin
        expect_equal("led0", 32'(exp_led), 32'(led0));
        expect_equal("himux", 32'(HIMUX_ROUTE), 32'(himux));
        expect_equal("azmux", 32'd0, 32'(azmux));
        expect_equal("sig_pc_sw_ctl", 32'd0, 32'(sig_pc_sw_ctl));
        expect_equal("monitor", 32'd0, 32'(monitor));
        step_clocks(1);
        run++;
      end
      expect_equal("charge phase length", 32'(run_len), 32'(run));
    end
  endtask

  // walks sclk, mosi and the chain return through all combinations
  task automatic probe_4094_port(input logic en);
    logic [2:0] v;
    int         k;
    spi_cs2 = 1'b0;
    for (k = 0; k < 8; k++)
    begin
      v = k[2:0];
      spi_clk = v[0];
      spi_mosi = v[1];
      u1004_4094_data = v[2];
      step_clocks(1);
      expect_equal("glb_4094_clk", 32'(en & v[0]), 32'(glb_4094_clk));
      expect_equal("glb_4094_data", 32'(en & v[1]), 32'(glb_4094_data));
      expect_equal("glb_4094_strobe", 32'(en), 32'(glb_4094_strobe));
      expect_equal("spi_miso", 32'(en & v[2]), 32'(spi_miso));
    end
    spi_cs2 = 1'b1;
    spi_clk = 1'b0;
    spi_mosi = 1'b0;
    u1004_4094_data = 1'b0;
    step_clocks(1);
    expect_equal("glb_4094_strobe", 32'd0, 32'(glb_4094_strobe));
    expect_equal("spi_miso", 32'd0, 32'(spi_miso));
  endtask

  //////////////////////////////
  // main sequence

  initial
  begin
    entry_t      ent;
    logic [23:0] wdata;
    logic [23:0] rd_word;
    int          idx;
    clk = 1'b0;
    reset = 1'b1;
    spi_clk = 1'b0;
    spi_cs = 1'b1;
    spi_cs2 = 1'b1;
    spi_mosi = 1'b0;
    u1004_4094_data = 1'b0;
    seed = 32'h26e7_e0a9;
    for (idx = 0; idx < 256; idx++)
      reg_model[idx] = '0;
    step_clocks(8);
    reset = 1'b0;

    for (idx = 0; idx < N_ENTRIES; idx++)
    begin
      ent = stim[idx];
      case (ent.op)
        OP_WRITE, OP_WRITE_PINS:
        begin
          wdata = ent.data;
          if (ent.op == OP_WRITE_PINS)
          begin
            rnd = $random(seed);
            wdata = rnd[23:0];
          end
          spi_transfer(32, ent.addr, wdata, rd_word);
          expect_equal($sformatf("readback of 0x%02h", ent.addr),
                       32'(expected_read(ent.addr)), 32'(rd_word));
          if (addr_mapped(ent.addr))
            reg_model[ent.addr] = wdata;
          if (ent.op == OP_WRITE_PINS)
            compare_direct_pins(wdata);
        end
        // dropped frame leaves the model as it is
        OP_SHORT:   spi_transfer(31, ent.addr, ent.data, rd_word);
        OP_PATTERN: watch_pattern(int'(ent.expect_val));
        OP_COUNT:   watch_count(int'(ent.expect_val));
        OP_CHARGE:  watch_charge(int'(ent.expect_val));
        default:    probe_4094_port(ent.expect_val[0]);
      endcase
    end

    $display("TESTBENCH PASSED");
    $finish;
  end

endmodule

// File: dmm_fpga_top.sv
// dmm output control top
// spi register bank, 4094 port switch, drive sources and the
// mode selection, with the drive word split onto the pins
`timescale 1ns/1ps

module dmm_fpga_top #(
  parameter int PHASE_CYCLES = 20_000_000,
  parameter int LOG2_BLINK   = 22
) (
  input  logic                                      clk,
  input  logic                                      reset,
  input  logic                                      spi_clk,
  input  logic                                      spi_cs,
  input  logic                                      spi_cs2,
  input  logic                                      spi_mosi,
  input  logic                                      u1004_4094_data,
  output logic                                      spi_miso,
  output logic                                      glb_4094_clk,
  output logic                                      glb_4094_data,
  output logic                                      glb_4094_strobe,
  output logic [dmm_drive_pkg::MUX_BITS-1:0]        azmux,
  output logic [dmm_drive_pkg::MUX_BITS-1:0]        himux,
  output logic [dmm_drive_pkg::MUX_BITS-1:0]        himux2,
  output logic                                      sig_pc_sw_ctl,
  output logic                                      led0,
  output logic [dmm_drive_pkg::MONITOR_BITS-1:0]    monitor
);
  import dmm_regs_pkg::*;
  import dmm_drive_pkg::*;

  logic                 spi_dout;
  logic [REG_WIDTH-1:0] reg_spi_mux;
  drive_mode_t          reg_mode;
  logic [REG_WIDTH-1:0] reg_direct;
  logic                 mode_load;
  drive_t               pattern;
  drive_t               charge;
  drive_t               drive;

  //////////////////////////////
  // spi side

  // led register is a readback scratch register only
  spi_reg_bank i_spi_reg_bank (
    .clk         (clk),
    .reset       (reset),
    .spi_clk     (spi_clk),
    .spi_cs      (spi_cs),
    .spi_mosi    (spi_mosi),
    .spi_dout    (spi_dout),
    .reg_led     (),
    .reg_spi_mux (reg_spi_mux),
    .reg_mode    (reg_mode),
    .reg_direct  (reg_direct),
    .mode_load   (mode_load)
  );

  spi_port_mux i_spi_port_mux (
    .spi_clk         (spi_clk),
    .spi_cs          (spi_cs),
    .spi_cs2         (spi_cs2),
    .spi_mosi        (spi_mosi),
    .spi_dout        (spi_dout),
    .reg_spi_mux     (reg_spi_mux),
    .u1004_4094_data (u1004_4094_data),
    .glb_4094_clk    (glb_4094_clk),
    .glb_4094_data   (glb_4094_data),
    .glb_4094_strobe (glb_4094_strobe),
    .spi_miso        (spi_miso)
  );

  //////////////////////////////
  // drive sources

  pattern_gen #(
    .LOG2_BLINK (LOG2_BLINK)
  ) i_pattern_gen (
    .clk     (clk),
    .reset   (reset),
    .pattern (pattern)
  );

  charge_cycle_seq #(
    .PHASE_CYCLES (PHASE_CYCLES)
  ) i_charge_cycle_seq (
    .clk       (clk),
    .reset     (reset),
    .mode_load (mode_load),
    .charge    (charge)
  );

  drive_select i_drive_select (
    .clk     (clk),
    .reset   (reset),
    .mode    (reg_mode),
    .pattern (pattern),
    .direct  (reg_direct),
    .charge  (charge),
    .drive   (drive)
  );

  //////////////////////////////
  // pin fields

  // each mux is {en, a2, a1, a0}
  assign azmux         = drive[AZMUX_LSB +: MUX_BITS];
  assign himux         = drive[HIMUX_LSB +: MUX_BITS];
  assign himux2        = drive[HIMUX2_LSB +: MUX_BITS];
  assign sig_pc_sw_ctl = drive[PC_SW_BIT];
  assign led0          = drive[LED0_BIT];
  assign monitor       = drive[MONITOR_LSB +: MONITOR_BITS];

endmodule

// File: drive_select.sv
// output mode selection
// registers one of pattern, direct register, binary count or the
// charge sequence onto the drive word
`timescale 1ns/1ps

module drive_select (
  input  logic                                clk,
  input  logic                                reset,
  input  dmm_regs_pkg::drive_mode_t           mode,
  input  dmm_drive_pkg::drive_t               pattern,
  input  logic [dmm_regs_pkg::REG_WIDTH-1:0]  direct,
  input  dmm_drive_pkg::drive_t               charge,
  output dmm_drive_pkg::drive_t               drive
);
  import dmm_regs_pkg::*;
  import dmm_drive_pkg::*;

  drive_t count;
  drive_t next_drive;

  // binary count source, wraps at 2^22
  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
      count <= '0;
    else
      count <= count + 1'b1;
  end

  always_comb
  begin
    case (mode)
      MODE_PATTERN: next_drive = pattern;
      // top two register bits are spare
      MODE_DIRECT:  next_drive = direct[DRIVE_BITS-1:0];
      MODE_COUNT:   next_drive = count;
      default:      next_drive = charge;
    endcase
  end

  // one clock from source to pins
  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
      drive <= '0;
    else
      drive <= next_drive;
  end

endmodule

// File: charge_cycle_seq.sv
// accumulation cap charge sequence
// grounds the cap through himux2 for one phase, then selects the
// dc source for one phase, and repeats
`timescale 1ns/1ps

module charge_cycle_seq #(
  parameter int PHASE_CYCLES = 20_000_000
) (
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   mode_load,
  output dmm_drive_pkg::drive_t  charge
);
  import dmm_drive_pkg::*;

  localparam int CNT_BITS = $clog2(2 * PHASE_CYCLES);
  // last count of the second phase
  localparam logic [CNT_BITS-1:0] CNT_LAST = CNT_BITS'(2 * PHASE_CYCLES - 1);
  // first count of the source phase
  localparam logic [CNT_BITS-1:0] CNT_EDGE = CNT_BITS'(PHASE_CYCLES);

  logic [CNT_BITS-1:0] phase_cnt;

  //////////////////////////////
  // phase counter

  // a mode write restarts the sequence in the ground phase
  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
      phase_cnt <= '0;
    else if (mode_load)
      phase_cnt <= '0;
    else if (phase_cnt == CNT_LAST)
      phase_cnt <= '0;
    else
      phase_cnt <= phase_cnt + 1'b1;
  end

  //////////////////////////////
  // output decode

  always_comb
  begin
    // pre-charge and monitor stay low
    charge = '0;
    charge[AZMUX_LSB +: MUX_BITS] = MUX_OFF;
    // himux feeds the himux2 output onward in both phases
    charge[HIMUX_LSB +: MUX_BITS] = HIMUX_SEL_HIMUX2;
    if (phase_cnt < CNT_EDGE)
    begin
      // discharge phase, led off
      charge[HIMUX2_LSB +: MUX_BITS] = HIMUX2_SEL_GND;
      charge[LED0_BIT]               = 1'b0;
    end
    else
    begin
      // charge from dc source, led on
      charge[HIMUX2_LSB +: MUX_BITS] = HIMUX2_SEL_DCV;
      charge[LED0_BIT]               = 1'b1;
    end
  end

endmodule

// File: pattern_gen.sv
// test pattern source
// free running counter, slow blinking led and a monitor byte that
// steps every clock, switches held open
`timescale 1ns/1ps

module pattern_gen #(
  parameter int LOG2_BLINK = 22
) (
  input  logic                   clk,
  input  logic                   reset,
  output dmm_drive_pkg::drive_t  pattern
);
  import dmm_drive_pkg::*;

  logic [31:0] counter;

  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
      counter <= '0;
    else
      counter <= counter + 1'b1;
  end

  always_comb
  begin
    pattern = '0;
    // all switches open, pre-charge off
    pattern[AZMUX_LSB +: MUX_BITS]  = MUX_OFF;
    pattern[HIMUX_LSB +: MUX_BITS]  = MUX_OFF;
    pattern[HIMUX2_LSB +: MUX_BITS] = MUX_OFF;
    pattern[PC_SW_BIT]              = 1'b0;
    // led toggles every 2^LOG2_BLINK clocks
    pattern[LED0_BIT]               = counter[LOG2_BLINK];
    pattern[MONITOR_LSB +: MONITOR_BITS] = counter[MONITOR_BITS-1:0];
  end

endmodule

// File: spi_port_mux.sv
// spi port switch
// hands the mcu spi lines to the 4094 chain under cs2 and
// picks which slave drives miso
`timescale 1ns/1ps

module spi_port_mux (
  input  logic                                spi_clk,
  input  logic                                spi_cs,
  input  logic                                spi_cs2,
  input  logic                                spi_mosi,
  input  logic                                spi_dout,
  input  logic [dmm_regs_pkg::REG_WIDTH-1:0]  reg_spi_mux,
  input  logic                                u1004_4094_data,
  output logic                                glb_4094_clk,
  output logic                                glb_4094_data,
  output logic                                glb_4094_strobe,
  output logic                                spi_miso
);

  // 4094 strobe latches on high
  localparam logic STROBE_ACTIVE = 1'b1;

  logic port_en;

  // mcu has enabled the port and is talking to the chain
  assign port_en = reg_spi_mux[0] & ~spi_cs2;

  //////////////////////////////
  // forward path

  assign glb_4094_clk    = port_en & spi_clk;
  assign glb_4094_data   = port_en & spi_mosi;
  assign glb_4094_strobe = port_en ? STROBE_ACTIVE : 1'b0;

  //////////////////////////////
  // return path

  always_comb
  begin
    if (!spi_cs)
      spi_miso = spi_dout;
    else if (port_en)
      // chain tail data back to the mcu
      spi_miso = u1004_4094_data;
    else
      spi_miso = 1'b0;
  end

endmodule

// File: spi_reg_bank.sv
// spi register bank
// oversampled mode 0 slave, 8 bit address then 24 bit data.
// every frame returns the old register content in its data phase
// and commits only if exactly 32 bits were clocked
`timescale 1ns/1ps

module spi_reg_bank (
  input  logic                                clk,
  input  logic                                reset,
  input  logic                                spi_clk,
  input  logic                                spi_cs,
  input  logic                                spi_mosi,
  output logic                                spi_dout,
  output logic [dmm_regs_pkg::REG_WIDTH-1:0]  reg_led,
  output logic [dmm_regs_pkg::REG_WIDTH-1:0]  reg_spi_mux,
  output dmm_regs_pkg::drive_mode_t           reg_mode,
  output logic [dmm_regs_pkg::REG_WIDTH-1:0]  reg_direct,
  output logic                                mode_load
);
  import dmm_regs_pkg::*;

  // counter saturates one past a full frame so long frames stay invalid
  localparam int CNT_BITS = $clog2(FRAME_BITS + 2);
  localparam logic [CNT_BITS-1:0] CNT_FULL      = CNT_BITS'(FRAME_BITS);
  localparam logic [CNT_BITS-1:0] CNT_OVER      = CNT_BITS'(FRAME_BITS + 1);
  localparam logic [CNT_BITS-1:0] CNT_ADDR      = CNT_BITS'(ADDR_BITS);
  localparam logic [CNT_BITS-1:0] CNT_LAST_ADDR = CNT_BITS'(ADDR_BITS - 1);

  logic [1:0]            sclk_sync;
  logic [1:0]            cs_sync;
  logic [1:0]            mosi_sync;
  logic                  sclk_prev;
  logic                  cs_prev;
  logic                  sclk_rise;
  logic                  sclk_fall;
  logic                  cs_active;
  logic                  cs_rise;
  logic [CNT_BITS-1:0]   bit_cnt;
  logic [FRAME_BITS-1:0] shift_in;
  logic [REG_WIDTH-1:0]  shift_out;
  logic [ADDR_BITS-1:0]  rd_addr;
  logic [REG_WIDTH-1:0]  rd_data;
  logic [ADDR_BITS-1:0]  wr_addr;
  logic [REG_WIDTH-1:0]  wr_data;
  logic                  commit;
  logic [REG_WIDTH-1:0]  mode_q;

  //////////////////////////////
  // pin synchronizers

  // cs idles high, so it comes out of reset deasserted
  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      sclk_sync <= 2'b00;
      cs_sync   <= 2'b11;
      mosi_sync <= 2'b00;
      sclk_prev <= 1'b0;
      cs_prev   <= 1'b1;
    end
    else
    begin
      sclk_sync <= {sclk_sync[0], spi_clk};
      cs_sync   <= {cs_sync[0], spi_cs};
      mosi_sync <= {mosi_sync[0], spi_mosi};
      sclk_prev <= sclk_sync[1];
      cs_prev   <= cs_sync[1];
    end
  end

  assign sclk_rise = sclk_sync[1] & ~sclk_prev;
  assign sclk_fall = ~sclk_sync[1] & sclk_prev;
  assign cs_active = ~cs_sync[1];
  assign cs_rise   = cs_sync[1] & ~cs_prev;

  //////////////////////////////
  // bit count and dout

  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      bit_cnt  <= '0;
      spi_dout <= 1'b0;
    end
    else if (!cs_active)
    begin
      bit_cnt  <= '0;
      spi_dout <= 1'b0;
    end
    else
    begin
      if (sclk_rise && bit_cnt != CNT_OVER)
        bit_cnt <= bit_cnt + 1'b1;
      // address phase returns zeros, data phase the old register
      if (sclk_fall)
        spi_dout <= (bit_cnt >= CNT_ADDR) ? shift_out[REG_WIDTH-1] : 1'b0;
    end
  end

  // address as it stands once the eighth bit is taken
  assign rd_addr = {shift_in[ADDR_BITS-2:0], mosi_sync[1]};

  always_comb
  begin
    case (rd_addr)
      REG_LED:     rd_data = reg_led;
      REG_SPI_MUX: rd_data = reg_spi_mux;
      REG_MODE:    rd_data = mode_q;
      REG_DIRECT:  rd_data = reg_direct;
      default:     rd_data = '0;
    endcase
  end

  always_ff @(posedge clk)
  begin
    if (cs_active && sclk_rise)
    begin
      shift_in <= {shift_in[FRAME_BITS-2:0], mosi_sync[1]};
      if (bit_cnt == CNT_LAST_ADDR)
        shift_out <= rd_data;
    end
    if (cs_active && sclk_fall && bit_cnt >= CNT_ADDR)
      shift_out <= {shift_out[REG_WIDTH-2:0], 1'b0};
  end

  //////////////////////////////
  // register write on cs release

  assign wr_addr = shift_in[FRAME_BITS-1 -: ADDR_BITS];
  assign wr_data = shift_in[REG_WIDTH-1:0];
  assign commit  = cs_rise && (bit_cnt == CNT_FULL);

  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      reg_led     <= '0;
      reg_spi_mux <= '0;
      mode_q      <= '0;
      reg_direct  <= '0;
      mode_load   <= 1'b0;
    end
    else
    begin
      mode_load <= 1'b0;
      if (commit)
      begin
        case (wr_addr)
          REG_LED:     reg_led <= wr_data;
          REG_SPI_MUX: reg_spi_mux <= wr_data;
          REG_MODE:
          begin
            mode_q    <= wr_data;
            mode_load <= 1'b1;
          end
          REG_DIRECT:  reg_direct <= wr_data;
          default:     ;
        endcase
      end
    end
  end

  assign reg_mode = drive_mode_t'(mode_q[1:0]);

endmodule

// File: dmm_drive_pkg.sv
// dmm output drive word
// layout of the 22 bit word that drives the analog switches,
// the pre-charge switch, the led and the monitor port
package dmm_drive_pkg;

  // total width of the drive word
  localparam int DRIVE_BITS = 22;
  // each mux is an enable bit over 3 address bits
  localparam int MUX_BITS = 4;
  localparam int MONITOR_BITS = 8;

  // packed word, msb down: monitor, led0, pc sw, himux2, himux, azmux
  typedef logic [DRIVE_BITS-1:0] drive_t;

  //////////////////////////////
  // field positions

  localparam int AZMUX_LSB   = 0;
  localparam int HIMUX_LSB   = AZMUX_LSB + MUX_BITS;
  localparam int HIMUX2_LSB  = HIMUX_LSB + MUX_BITS;
  localparam int PC_SW_BIT   = HIMUX2_LSB + MUX_BITS;
  localparam int LED0_BIT    = PC_SW_BIT + 1;
  localparam int MONITOR_LSB = LED0_BIT + 1;

  //////////////////////////////
  // switch select codes

  // enable clear, all switches open
  localparam logic [MUX_BITS-1:0] MUX_OFF          = 4'b0000;
  // himux s2, routes himux2 through
  localparam logic [MUX_BITS-1:0] HIMUX_SEL_HIMUX2 = 4'b1001;
  // himux2 s4, ground to discharge the cap
  localparam logic [MUX_BITS-1:0] HIMUX2_SEL_GND   = 4'b1011;
  // himux2 s1, dc source hi
  localparam logic [MUX_BITS-1:0] HIMUX2_SEL_DCV   = 4'b1000;

endpackage

// File: dmm_regs_pkg.sv
// dmm register map
// addresses, register width and the drive mode encoding used by
// the spi register bank and the output mode selection
package dmm_regs_pkg;

  //////////////////////////////
  // frame geometry

  // data width of every register
  localparam int REG_WIDTH = 24;
  // address byte leads the frame
  localparam int ADDR_BITS = 8;
  // full frame, address then data
  localparam int FRAME_BITS = ADDR_BITS + REG_WIDTH;

  //////////////////////////////
  // register addresses

  // anything else is ignored on write and reads as zero
  typedef enum logic [ADDR_BITS-1:0] {
    REG_LED     = 8'h07,
    REG_SPI_MUX = 8'h08,
    REG_MODE    = 8'h0A,
    REG_DIRECT  = 8'h0C
  } reg_addr_t;

  // output drive mode, low two bits of the mode register
  typedef enum logic [1:0] {
    MODE_PATTERN = 2'd0,
    MODE_DIRECT  = 2'd1,
    MODE_COUNT   = 2'd2,
    MODE_CHARGE  = 2'd3
  } drive_mode_t;

endpackage
